// File: logic/uart_pkg.sv
package uart_pkg;

// ==========================================================
// sizing
// ==========================================================

// entries per FIFO, power of two
localparam int FIFO_DEPTH = 2;
localparam int OVERSAMPLE = 8;
localparam int W_OVER     = 3;
// holds 0..FIFO_DEPTH inclusive
localparam int W_FLEVEL   = 2;
localparam int W_DIV_INT  = 10;
localparam int W_DIV_FRAC = 8;

// register byte offsets
localparam logic [15:0] ADDR_CSR   = 16'h0000;
localparam logic [15:0] ADDR_DIV   = 16'h0004;
localparam logic [15:0] ADDR_FSTAT = 16'h0008;
localparam logic [15:0] ADDR_TX    = 16'h000c;
localparam logic [15:0] ADDR_RX    = 16'h0010;

// tx states, data bits occupy the states between start and stop
localparam logic [3:0] TX_IDLE  = 4'd0;
localparam logic [3:0] TX_START = 4'd1;
localparam logic [3:0] TX_STOP  = 4'd10;

// rx states, start1 is a full bit and start2 a half bit
localparam logic [3:0] RX_IDLE   = 4'd0;
localparam logic [3:0] RX_START1 = 4'd1;
localparam logic [3:0] RX_START2 = 4'd2;
localparam logic [3:0] RX_STOP   = 4'd11;

typedef struct packed {
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
} apb_req_t;

typedef struct packed {
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
} apb_rsp_t;

typedef struct packed {
	logic [W_FLEVEL-1:0] level;
	logic                full;
	logic                empty;
} fifo_stat_t;

endpackage

// File: logic/clkdiv_frac.sv
module clkdiv_frac import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en_i,
	input  logic [W_DIV_INT-1:0]  div_int_i,
	input  logic [W_DIV_FRAC-1:0] div_frac_i,
	output logic                  tick_o
);

logic [W_DIV_INT-1:0]  ctr;
logic [W_DIV_FRAC-1:0] acc;
logic [W_DIV_FRAC:0]   acc_sum;
// one extra cycle owed after the accumulator carried
logic                  stretch;

assign acc_sum = {1'b0, acc} + {1'b0, div_frac_i};

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		ctr <= '0;
		acc <= '0;
		stretch <= 1'b0;
		tick_o <= 1'b0;
	end else if (!en_i) begin
		ctr <= '0;
		acc <= '0;
		stretch <= 1'b0;
		tick_o <= 1'b0;
	end else begin
		tick_o <= 1'b0;
		if (ctr != '0) begin
			ctr <= ctr - 1'b1;
		end else if (stretch) begin
			stretch <= 1'b0;
		end else begin
			// end of period, reload and fold in the fraction
			tick_o <= 1'b1;
			ctr <= div_int_i - 1'b1;
			acc <= acc_sum[W_DIV_FRAC-1:0];
			stretch <= acc_sum[W_DIV_FRAC];
		end
	end
end

endmodule

// File: logic/sync_fifo.sv
module sync_fifo import uart_pkg::*; #(
	parameter int DEPTH = FIFO_DEPTH
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push_i,
	input  logic [7:0] push_data_i,
	input  logic       pop_i,
	output logic [7:0] pop_data_o,
	output fifo_stat_t stat_o
);

localparam int W_ADDR = $clog2(DEPTH);

logic [7:0]      mem [DEPTH];
// pointers carry one wrap bit above the address
logic [W_ADDR:0] wptr;
logic [W_ADDR:0] rptr;
logic [W_ADDR:0] used;
logic            full;
logic            empty;
logic            do_push;
logic            do_pop;

assign used = wptr - rptr;

// used never exceeds DEPTH, so its top bit alone means full
assign full  = used[W_ADDR];
assign empty = (used == '0);

assign do_push = push_i && !full;
assign do_pop  = pop_i && !empty;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wptr <= '0;
		rptr <= '0;
	end else begin
		if (do_push) begin
			wptr <= wptr + 1'b1;
		end
		if (do_pop) begin
			rptr <= rptr + 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (do_push) begin
		mem[wptr[W_ADDR-1:0]] <= push_data_i;
	end
end

// head entry, shown without a read latency
assign pop_data_o = mem[rptr[W_ADDR-1:0]];

assign stat_o = '{
	level: W_FLEVEL'(used),
	full:  full,
	empty: empty
};

endmodule

// File: logic/uart_tx.sv
module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en_i,
	input  logic       tick_i,
	input  logic [7:0] fifo_data_i,
	input  logic       fifo_empty_i,
	output logic       fifo_pop_o,
	output logic       busy_o,
	output logic       tx_o
);

logic [W_OVER-1:0] over_ctr;
logic [3:0]        state;
logic [7:0]        shifter;
// one step per bit period
logic              adv;

assign adv = en_i && tick_i && (over_ctr == '0);

// take the next byte on the way out of idle or stop
assign fifo_pop_o = adv && !fifo_empty_i &&
	(state == TX_IDLE || state == TX_STOP);

assign busy_o = (state != TX_IDLE) || !fifo_empty_i;

// ==========================================================
// frame sequencing
// ==========================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= TX_IDLE;
		over_ctr <= '0;
		tx_o <= 1'b1;
	end else if (!en_i) begin
		state <= TX_IDLE;
		over_ctr <= '0;
		tx_o <= 1'b1;
	end else begin
		if (tick_i) begin
			over_ctr <= over_ctr + 1'b1;
		end
		if (adv) begin
			case (state)
			TX_IDLE, TX_STOP: begin
				if (fifo_empty_i) begin
					// park the counter so a new byte goes out on the next tick
					state <= TX_IDLE;
					over_ctr <= '0;
				end else begin
					state <= TX_START;
					tx_o <= 1'b0;
				end
			end
			default: begin
				// start and data states, the last shift brings up the stop bit
				state <= state + 1'b1;
				tx_o <= shifter[0];
			end
			endcase
		end
	end
end

// lsb first, ones fill in from the top and become the stop level
always_ff @(posedge clk) begin
	if (fifo_pop_o) begin
		shifter <= fifo_data_i;
	end else if (adv && state != TX_IDLE) begin
		shifter <= {1'b1, shifter[7:1]};
	end
end

endmodule

// File: logic/uart_rx.sv
module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en_i,
	input  logic       tick_i,
	input  logic       rx_i,
	output logic       push_o,
	output logic [7:0] data_o
);

logic [1:0]        rx_sync;
logic              rx_s;
logic [W_OVER-1:0] over_ctr;
logic [3:0]        state;
logic [7:0]        shifter;
logic              adv;
logic              sample;

// two flop synchroniser that resets to the idle high level
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rx_sync <= 2'b11;
	end else begin
		rx_sync <= {rx_sync[0], rx_i};
	end
end

assign rx_s = rx_sync[1];

assign adv = en_i && tick_i && (over_ctr == '0);

// data bits are taken at the end of start2 and the seven states after it
assign sample = adv && (state >= RX_START2) && (state <= RX_STOP - 4'd2);

// ==========================================================
// frame sequencing
// ==========================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= RX_IDLE;
		over_ctr <= '0;
		push_o <= 1'b0;
	end else if (!en_i) begin
		state <= RX_IDLE;
		over_ctr <= '0;
		push_o <= 1'b0;
	end else begin
		push_o <= 1'b0;
		if (tick_i) begin
			over_ctr <= over_ctr + 1'b1;
		end
		if (adv) begin
			state <= state + 1'b1;
			case (state)
			RX_IDLE: begin
				if (rx_s) begin
					// counting starts from the first low tick
					state <= RX_IDLE;
					over_ctr <= '0;
				end
			end
			RX_START1: begin
				// the next state lasts half a bit and lands on mid-bit
				over_ctr <= W_OVER'(OVERSAMPLE / 2 + 1);
			end
			RX_STOP - 4'd1: begin
				// a low stop sample drops the frame
				push_o <= rx_s;
				// back from mid-bit to the bit edge
				over_ctr <= W_OVER'(OVERSAMPLE / 2 + 1);
			end
			RX_STOP: begin
				// idle looks at the line again on the next tick
				state <= RX_IDLE;
				over_ctr <= '0;
			end
			default: begin
			end
			endcase
		end
	end
end

always_ff @(posedge clk) begin
	if (sample) begin
		shifter <= {rx_s, shifter[7:1]};
	end
end

assign data_o = shifter;

endmodule

// File: logic/uart_regs.sv
module uart_regs import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  apb_req_t              apb_req_i,
	output apb_rsp_t              apb_rsp_o,
	output logic                  en_o,
	output logic                  txie_o,
	output logic                  rxie_o,
	output logic [W_DIV_INT-1:0]  div_int_o,
	output logic [W_DIV_FRAC-1:0] div_frac_o,
	input  logic                  busy_i,
	input  fifo_stat_t            tx_stat_i,
	input  fifo_stat_t            rx_stat_i,
	output logic                  tx_push_o,
	output logic [7:0]            tx_data_o,
	output logic                  rx_pop_o,
	input  logic [7:0]            rx_data_i
);

logic        access;
logic        wr;
logic        rd;
logic        sel_csr;
logic        sel_div;
logic        sel_fstat;
logic        sel_tx;
logic        sel_rx;
logic        mapped;
logic        err;
logic [31:0] rdata;

// access phase of a transfer, there are no wait states
assign access = apb_req_i.psel && apb_req_i.penable;
assign wr = access && apb_req_i.pwrite;
assign rd = access && !apb_req_i.pwrite;

assign sel_csr   = (apb_req_i.paddr == ADDR_CSR);
assign sel_div   = (apb_req_i.paddr == ADDR_DIV);
assign sel_fstat = (apb_req_i.paddr == ADDR_FSTAT);
assign sel_tx    = (apb_req_i.paddr == ADDR_TX);
assign sel_rx    = (apb_req_i.paddr == ADDR_RX);
assign mapped = sel_csr || sel_div || sel_fstat || sel_tx || sel_rx;

// status and rx are read only, tx is write only
assign err = access && (!mapped ||
	(wr && (sel_fstat || sel_rx)) ||
	(rd && sel_tx));

// ==========================================================
// control registers
// ==========================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		en_o <= 1'b0;
		txie_o <= 1'b0;
		rxie_o <= 1'b0;
		div_int_o <= '0;
		div_frac_o <= '0;
	end else if (wr) begin
		if (sel_csr) begin
			en_o <= apb_req_i.pwdata[0];
			txie_o <= apb_req_i.pwdata[8];
			rxie_o <= apb_req_i.pwdata[9];
		end
		if (sel_div) begin
			div_frac_o <= apb_req_i.pwdata[W_DIV_FRAC-1:0];
			div_int_o <= apb_req_i.pwdata[W_DIV_FRAC +: W_DIV_INT];
		end
	end
end

// full fifo drops the write
assign tx_push_o = wr && sel_tx && !tx_stat_i.full;
assign tx_data_o = apb_req_i.pwdata[7:0];

assign rx_pop_o = rd && sel_rx && !rx_stat_i.empty;

// ==========================================================
// read data
// ==========================================================

always_comb begin
	rdata = '0;
	if (sel_csr) begin
		rdata = {22'b0, rxie_o, txie_o, 6'b0, busy_i, en_o};
	end else if (sel_div) begin
		rdata = {{(32 - W_DIV_INT - W_DIV_FRAC){1'b0}}, div_int_o, div_frac_o};
	end else if (sel_fstat) begin
		rdata = {6'b0, rx_stat_i.empty, rx_stat_i.full,
			{(8 - W_FLEVEL){1'b0}}, rx_stat_i.level,
			6'b0, tx_stat_i.empty, tx_stat_i.full,
			{(8 - W_FLEVEL){1'b0}}, tx_stat_i.level};
	end else if (sel_rx && !rx_stat_i.empty) begin
		// an empty fifo reads as zero
		rdata = {24'b0, rx_data_i};
	end
end

assign apb_rsp_o = '{
	prdata:  rdata,
	pready:  1'b1,
	pslverr: err
};

endmodule

// File: logic/uart_mini.sv
module uart_mini import uart_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	input  logic     rx_i,
	output logic     tx_o,
	output logic     irq_o,
	output logic     dreq_o
);

logic                  en;
logic                  txie;
logic                  rxie;
logic                  tick;
logic                  tx_busy;
logic [W_DIV_INT-1:0]  div_int;
logic [W_DIV_FRAC-1:0] div_frac;

fifo_stat_t            tx_stat;
logic                  tx_push;
logic                  tx_pop;
logic [7:0]            tx_wdata;
logic [7:0]            tx_rdata;

fifo_stat_t            rx_stat;
logic                  rx_push;
logic                  rx_pop;
logic [7:0]            rx_wdata;
logic [7:0]            rx_rdata;

// room to write or data to read
assign irq_o = (txie && !tx_stat.full) || (rxie && !rx_stat.empty);
assign dreq_o = irq_o;

// ==========================================================
// baud tick and serial engines
// ==========================================================

clkdiv_frac clkdiv0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.en_i       (en),
	.div_int_i  (div_int),
	.div_frac_i (div_frac),
	.tick_o     (tick)
);

uart_tx tx0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.en_i         (en),
	.tick_i       (tick),
	.fifo_data_i  (tx_rdata),
	.fifo_empty_i (tx_stat.empty),
	.fifo_pop_o   (tx_pop),
	.busy_o       (tx_busy),
	.tx_o         (tx_o)
);

uart_rx rx0 (
	.clk    (clk),
	.rst_n  (rst_n),
	.en_i   (en),
	.tick_i (tick),
	.rx_i   (rx_i),
	.push_o (rx_push),
	.data_o (rx_wdata)
);

// ==========================================================
// fifos and register block
// ==========================================================

sync_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo (
	.clk         (clk),
	.rst_n       (rst_n),
	.push_i      (tx_push),
	.push_data_i (tx_wdata),
	.pop_i       (tx_pop),
	.pop_data_o  (tx_rdata),
	.stat_o      (tx_stat)
);

sync_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo (
	.clk         (clk),
	.rst_n       (rst_n),
	.push_i      (rx_push),
	.push_data_i (rx_wdata),
	.pop_i       (rx_pop),
	.pop_data_o  (rx_rdata),
	.stat_o      (rx_stat)
);

uart_regs regs0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.apb_req_i  (apb_req_i),
	.apb_rsp_o  (apb_rsp_o),
	.en_o       (en),
	.txie_o     (txie),
	.rxie_o     (rxie),
	.div_int_o  (div_int),
	.div_frac_o (div_frac),
	.busy_i     (tx_busy),
	.tx_stat_i  (tx_stat),
	.rx_stat_i  (rx_stat),
	.tx_push_o  (tx_push),
	.tx_data_o  (tx_wdata),
	.rx_pop_o   (rx_pop),
	.rx_data_i  (rx_rdata)
);

endmodule

// File: dv/uart_asserts.sv
module uart_asserts import uart_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input apb_req_t              apb_req_i,
	input apb_rsp_t              apb_rsp_o,
	input logic [W_DIV_INT-1:0]  div_int_o,
	input logic [W_DIV_FRAC-1:0] div_frac_o,
	input fifo_stat_t            tx_stat_i,
	input fifo_stat_t            rx_stat_i
);

logic div_write;

assign div_write = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
	(apb_req_i.paddr == ADDR_DIV);

// a div write completes in its own access cycle with pready high
div_write_done: assert property (@(posedge clk) disable iff (!rst_n)
	div_write |=> $past(apb_rsp_o.pready) &&
		({div_int_o, div_frac_o} == $past(apb_req_i.pwdata[17:0])))
	else $error("div write did not complete in its access cycle");

// a push taken while full would raise the level past the depth
no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
	tx_stat_i.full |=> tx_stat_i.level <= $past(tx_stat_i.level))
	else $error("tx push while full");

// a pop taken while empty would wrap the count round to full
no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
	rx_stat_i.empty |=> !rx_stat_i.full)
	else $error("rx pop while empty");

endmodule

bind uart_regs uart_asserts asserts0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.apb_req_i  (apb_req_i),
	.apb_rsp_o  (apb_rsp_o),
	.div_int_o  (div_int_o),
	.div_frac_o (div_frac_o),
	.tx_stat_i  (tx_stat_i),
	.rx_stat_i  (rx_stat_i)
);

// File: dv/uart_tb.sv
module uart_tb import uart_pkg::*; ();

localparam int MAX_CYCLES = 20000;

logic     clk;
logic     rst_n;
apb_req_t req;
apb_rsp_t rsp;
logic     tx;
logic     irq;
logic     dreq;
logic     loopback;
logic     rx_drv;
logic     rx_line;
int       errors;
int       checks;
int       cycles;

// serial input is looped from tx or driven by the tests
assign rx_line = loopback ? tx : rx_drv;

uart_mini dut0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.apb_req_i (req),
	.apb_rsp_o (rsp),
	.rx_i      (rx_line),
	.tx_o      (tx),
	.irq_o     (irq),
	.dreq_o    (dreq)
);

initial begin
	clk = 1'b0;
	forever begin
		#10 clk = ~clk;
	end
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES) begin
		$display("run stopped, no progress within %0d cycles", MAX_CYCLES);
		$display("Test failed");
		$finish;
	end
end

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("ERR %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
	@(negedge clk);
	req.psel = 1'b1;
	req.penable = 1'b0;
	req.pwrite = 1'b1;
	req.paddr = addr;
	req.pwdata = data;
	@(negedge clk);
	req.penable = 1'b1;
	#5;
	err = rsp.pslverr;
	check_val("apb write pready", 32'h1, {31'b0, rsp.pready});
	@(negedge clk);
	req.psel = 1'b0;
	req.penable = 1'b0;
endtask

task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
	@(negedge clk);
	req.psel = 1'b1;
	req.penable = 1'b0;
	req.pwrite = 1'b0;
	req.paddr = addr;
	@(negedge clk);
	req.penable = 1'b1;
	// prdata is settled by mid access cycle
	#5;
	data = rsp.prdata;
	err = rsp.pslverr;
	check_val("apb read pready", 32'h1, {31'b0, rsp.pready});
	@(negedge clk);
	req.psel = 1'b0;
	req.penable = 1'b0;
endtask

// poll FSTAT until the rx fifo holds a byte and then pop it
task automatic recv_byte(output logic [7:0] b);
	logic [31:0] d;
	logic        e;
	d = 32'h0200_0000;
	while (d[25]) begin
		apb_read(ADDR_FSTAT, d, e);
	end
	apb_read(ADDR_RX, d, e);
	b = d[7:0];
endtask

// one frame on rx_drv at divisor 4 where a bit is 32 cycles
task automatic drive_frame(input logic [7:0] b, input logic stop);
	int i;
	@(negedge clk);
	rx_drv = 1'b0;
	repeat (32) @(negedge clk);
	for (i = 0; i < 8; i++) begin
		rx_drv = b[i];
		repeat (32) @(negedge clk);
	end
	rx_drv = stop;
	// a low stop level is lifted before the receiver looks for a new start
	repeat (24) @(negedge clk);
	rx_drv = 1'b1;
	repeat (8) @(negedge clk);
endtask

// ==========================================================
// directed tests
// ==========================================================

task automatic regs_after_reset();
	logic [31:0] d;
	logic        e;
	apb_read(ADDR_CSR, d, e);
	check_val("regs csr reset", 32'h0, d);
	apb_read(ADDR_DIV, d, e);
	check_val("regs div reset", 32'h0, d);
	check_val("regs lines reset", 32'h4, {29'b0, tx, dreq, irq});
	apb_read(ADDR_FSTAT, d, e);
	check_val("regs fstat reset", 32'h0200_0200, d);
	apb_write(ADDR_CSR, 32'hffff_ffff, e);
	apb_read(ADDR_CSR, d, e);
	check_val("regs csr readback", 32'h0000_0301, d);
	// txie with room in the tx fifo
	check_val("regs irq txie", 32'h3, {30'b0, dreq, irq});
	apb_write(ADDR_CSR, 32'h0, e);
	apb_write(ADDR_DIV, 32'hffff_ffff, e);
	apb_read(ADDR_DIV, d, e);
	check_val("regs div readback", 32'h0003_ffff, d);
endtask

task automatic frame_shape();
	logic [7:0] b;
	logic       e;
	int         i;
	b = 8'($urandom);
	loopback = 1'b0;
	apb_write(ADDR_DIV, 32'h0000_0400, e);
	apb_write(ADDR_CSR, 32'h1, e);
	apb_write(ADDR_TX, {24'b0, b}, e);
	while (tx !== 1'b0) @(negedge clk);
	repeat (15) @(negedge clk);
	check_val("frame start", 32'h0, {31'b0, tx});
	for (i = 0; i < 8; i++) begin
		repeat (32) @(negedge clk);
		check_val("frame data", {31'b0, b[i]}, {31'b0, tx});
	end
	repeat (32) @(negedge clk);
	check_val("frame stop", 32'h1, {31'b0, tx});
	repeat (32) @(negedge clk);
	apb_write(ADDR_CSR, 32'h0, e);
endtask

task automatic loopback_bytes();
	logic [7:0]  b [3];
	logic [7:0]  got;
	logic [31:0] d;
	logic        e;
	int          i;
	loopback = 1'b1;
	apb_write(ADDR_DIV, 32'h0000_0580, e);
	apb_write(ADDR_CSR, 32'h1, e);
	for (i = 0; i < 3; i++) begin
		b[i] = 8'($urandom);
		d = 32'h100;
		while (d[8]) begin
			apb_read(ADDR_FSTAT, d, e);
		end
		apb_write(ADDR_TX, {24'b0, b[i]}, e);
	end
	for (i = 0; i < 3; i++) begin
		recv_byte(got);
		check_val("loopback data", {24'b0, b[i]}, {24'b0, got});
	end
	apb_read(ADDR_RX, d, e);
	check_val("loopback empty read", 32'h0, d);
	apb_write(ADDR_CSR, 32'h0, e);
endtask

task automatic tx_backpressure();
	logic [7:0]  b [3];
	logic [31:0] d;
	logic        e;
	int          i;
	for (i = 0; i < 3; i++) begin
		b[i] = 8'($urandom);
		apb_write(ADDR_TX, {24'b0, b[i]}, e);
	end
	apb_read(ADDR_FSTAT, d, e);
	check_val("bp txfull", 32'h1, {31'b0, d[8]});
	check_val("bp txlevel", FIFO_DEPTH, {24'b0, d[7:0]});
	loopback = 1'b1;
	apb_write(ADDR_DIV, 32'h0000_0400, e);
	apb_write(ADDR_CSR, 32'h1, e);
	d = 32'h2;
	while (d[1]) begin
		apb_read(ADDR_CSR, d, e);
	end
	repeat (64) @(negedge clk);
	apb_read(ADDR_FSTAT, d, e);
	check_val("bp rxlevel", 32'h2, {24'b0, d[23:16]});
	for (i = 0; i < 2; i++) begin
		apb_read(ADDR_RX, d, e);
		check_val("bp data", {24'b0, b[i]}, d);
	end
	apb_read(ADDR_FSTAT, d, e);
	check_val("bp rxempty", 32'h1, {31'b0, d[25]});
	apb_write(ADDR_CSR, 32'h0, e);
endtask

task automatic irq_and_errors();
	logic [7:0]  b;
	logic [7:0]  got;
	logic [31:0] d;
	logic        e;
	b = 8'($urandom);
	loopback = 1'b1;
	apb_write(ADDR_CSR, 32'h201, e);
	check_val("irq idle", 32'h0, {31'b0, irq});
	apb_write(ADDR_TX, {24'b0, b}, e);
	while (irq !== 1'b1) @(negedge clk);
	check_val("irq dreq", 32'h1, {31'b0, dreq});
	recv_byte(got);
	check_val("irq data", {24'b0, b}, {24'b0, got});
	check_val("irq cleared", 32'h0, {30'b0, dreq, irq});
	// the tx stop bit ends and the receiver gets a bit period to settle in idle
	d = 32'h2;
	while (d[1]) begin
		apb_read(ADDR_CSR, d, e);
	end
	repeat (32) @(negedge clk);
	// frame with a low stop bit must be dropped
	loopback = 1'b0;
	drive_frame(8'($urandom), 1'b0);
	repeat (64) @(negedge clk);
	apb_read(ADDR_FSTAT, d, e);
	check_val("bad stop rxempty", 32'h1, {31'b0, d[25]});
	apb_write(ADDR_CSR, 32'h0, e);
	apb_read(16'h0014, d, e);
	check_val("err unmapped", 32'h1, {31'b0, e});
	apb_write(ADDR_RX, 32'h5a, e);
	check_val("err write rx", 32'h1, {31'b0, e});
	apb_read(ADDR_TX, d, e);
	check_val("err read tx", 32'h1, {31'b0, e});
	apb_read(ADDR_CSR, d, e);
	check_val("err csr ok", 32'h0, {31'b0, e});
endtask

initial begin
	req = '0;
	rst_n = 1'b0;
	loopback = 1'b1;
	rx_drv = 1'b1;
	errors = 0;
	checks = 0;
	cycles = 0;
	void'($urandom(32'hcac90fe5));
	repeat (10) @(negedge clk);
	rst_n = 1'b1;
	regs_after_reset();
	frame_shape();
	loopback_bytes();
	tx_backpressure();
	irq_and_errors();
	$display("checks %0d, errors %0d", checks, errors);
	if (errors == 0) begin
		$display("Test completed successfully");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

// File: compile.f
logic/uart_pkg.sv
logic/clkdiv_frac.sv
logic/sync_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_mini.sv
dv/uart_asserts.sv
dv/uart_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -j 0 -Mdir obj_dir \
		--top-module uart_tb -f compile.f
	./obj_dir/Vuart_tb | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module uart_tb -f compile.f

clean:
	rm -rf obj_dir $(LOG)
